/* source/fp32_pkg.sv */
// Single-precision number format
// Field layout and format constants

package fp32_pkg;

    // --------------------
    // Format widths

    // Biased exponent field
    localparam int EXP_W = 8;

    // Stored fraction, without the hidden bit
    localparam int MANT_W = 23;

    // Fraction plus hidden bit
    localparam int MANT_FULL_W = MANT_W + 1;

    // Aligned mantissa, hidden bit at the top and guard room below
    localparam int ALIGN_W = 48;

    // Adder output, one carry bit above the aligned width
    localparam int SUM_W = ALIGN_W + 1;

    // Leading-zero count over the aligned mantissa
    localparam int LZ_W = $clog2(ALIGN_W);

    // --------------------
    // Special encodings

    // Exponent shared by infinity and NaN
    localparam int EXP_MAX = 255;

    // Quiet NaN returned for every invalid case
    localparam logic [31:0] QNAN = 32'h7FC0_0001;

    // --------------------
    // Word views

    // Sign, biased exponent, fraction
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [MANT_W-1:0] mant;
    } fp32_fields_t;

    // Raw bits for transport and compare, fields for unpacking
    typedef union packed {
        logic [31:0]  raw;
        fp32_fields_t fields;
    } fp32_t;

endpackage

/* source/add_array_pkg.sv */
// Adder array organization
// Lane count and transfer types

package add_array_pkg;
    import fp32_pkg::*;

    // Number of parallel adder lanes, 2 or more
    localparam int NUM_LANES = 4;

    // Round-robin pointer width
    localparam int LANE_IDX_W = $clog2(NUM_LANES);

    // One operand pair
    typedef struct packed {
        fp32_t a;
        fp32_t b;
    } add_req_t;

    // One sum
    typedef struct packed {
        fp32_t res;
    } add_rsp_t;

endpackage

/* source/fp32_add_lane.sv */
`timescale 1ns/1ps
// Floating-point add lane
// Three-stage truncating fp32 adder

module fp32_add_lane
    import fp32_pkg::*;
    import add_array_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  add_req_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output add_rsp_t out_data
);

    // Stage 1 register contents
    typedef struct packed {
        logic               special;
        fp32_t              spec_res;
        logic               sign;
        logic               sub;
        logic [EXP_W-1:0]   exp;
        logic [ALIGN_W-1:0] mant_l;
        logic [ALIGN_W-1:0] mant_s;
    } s1_t;

    // Stage 2 register contents
    typedef struct packed {
        logic             special;
        fp32_t            spec_res;
        logic             sign;
        logic [EXP_W-1:0] exp;
        logic [SUM_W-1:0] mant;
    } s2_t;

    logic stall;
    logic s1_valid;
    logic s2_valid;
    s1_t  s1_d;
    s1_t  s1_q;
    s2_t  s2_d;
    s2_t  s2_q;
    fp32_t s3_d;
    fp32_t s3_q;

    fp32_t op_a;
    fp32_t op_b;
    fp32_t big;
    fp32_t little;
    logic  a_larger;
    logic  a_zero;
    logic  a_inf;
    logic  a_nan;
    logic  b_zero;
    logic  b_inf;
    logic  b_nan;
    logic [EXP_W-1:0]       exp_big;
    logic [EXP_W-1:0]       exp_small;
    logic [EXP_W-1:0]       exp_diff;
    logic [MANT_FULL_W-1:0] full_big;
    logic [MANT_FULL_W-1:0] full_small;

    logic [LZ_W-1:0]           lz;
    logic signed [EXP_W+1:0]   norm_exp;
    logic [EXP_W+1:0]          den_shift;
    logic [ALIGN_W-1:0]        norm_mant;
    logic [ALIGN_W-1:0]        den_mant;

    // Whole lane freezes while the result waits
    assign stall    = out_valid && !out_ready;
    assign in_ready = !stall;

    // --------------------
    // Stage 1 unpack and align
    assign op_a = in_data.a;
    assign op_b = in_data.b;

    // Class flags per operand
    assign a_zero = (op_a.fields.exp == '0) && (op_a.fields.mant == '0);
    assign a_inf  = (op_a.fields.exp == EXP_W'(EXP_MAX)) && (op_a.fields.mant == '0);
    assign a_nan  = (op_a.fields.exp == EXP_W'(EXP_MAX)) && (op_a.fields.mant != '0);
    assign b_zero = (op_b.fields.exp == '0) && (op_b.fields.mant == '0);
    assign b_inf  = (op_b.fields.exp == EXP_W'(EXP_MAX)) && (op_b.fields.mant == '0);
    assign b_nan  = (op_b.fields.exp == EXP_W'(EXP_MAX)) && (op_b.fields.mant != '0);

    // Magnitude order follows the raw bits without the sign
    assign a_larger = op_a.raw[EXP_W+MANT_W-1:0] >= op_b.raw[EXP_W+MANT_W-1:0];
    assign big      = a_larger ? op_a : op_b;
    assign little   = a_larger ? op_b : op_a;

    // Denormals sit at exponent 1 with no hidden bit
    assign exp_big    = (big.fields.exp == '0) ? EXP_W'(1) : big.fields.exp;
    assign exp_small  = (little.fields.exp == '0) ? EXP_W'(1) : little.fields.exp;
    assign exp_diff   = exp_big - exp_small;
    assign full_big   = {big.fields.exp != '0, big.fields.mant};
    assign full_small = {little.fields.exp != '0, little.fields.mant};

    always_comb begin
        s1_d.sign   = big.fields.sign;
        s1_d.sub    = big.fields.sign ^ little.fields.sign;
        s1_d.exp    = exp_big;
        s1_d.mant_l = {full_big, {(ALIGN_W-MANT_FULL_W){1'b0}}};
        // Shifts of 48 or more leave nothing
        s1_d.mant_s = {full_small, {(ALIGN_W-MANT_FULL_W){1'b0}}} >> exp_diff;
        // Special bypass, priority NaN then inf then zero
        s1_d.special      = 1'b1;
        s1_d.spec_res.raw = QNAN;
        if (a_nan || b_nan) begin
            s1_d.spec_res.raw = QNAN;
        end else if (a_inf && b_inf) begin
            // inf - inf is invalid
            s1_d.spec_res.raw = (op_a.fields.sign != op_b.fields.sign) ? QNAN : op_a.raw;
        end else if (a_inf) begin
            s1_d.spec_res = op_a;
        end else if (b_inf) begin
            s1_d.spec_res = op_b;
        end else if (a_zero) begin
            s1_d.spec_res = op_b;
        end else if (b_zero) begin
            s1_d.spec_res = op_a;
        end else begin
            s1_d.special = 1'b0;
        end
    end

    // --------------------
    // Stage 2 add or subtract
    always_comb begin
        s2_d.special  = s1_q.special;
        s2_d.spec_res = s1_q.spec_res;
        s2_d.sign     = s1_q.sign;
        s2_d.exp      = s1_q.exp;
        // Larger magnitude first, so no borrow out
        if (s1_q.sub) begin
            s2_d.mant = {1'b0, s1_q.mant_l} - {1'b0, s1_q.mant_s};
        end else begin
            s2_d.mant = {1'b0, s1_q.mant_l} + {1'b0, s1_q.mant_s};
        end
    end

    // --------------------
    // Stage 3 normalize and pack

    // Leading zeros below the carry bit, highest set bit wins
    always_comb begin
        lz = '0;
        for (int i = 0; i < ALIGN_W; i++) begin
            if (s2_q.mant[i]) begin
                lz = LZ_W'(ALIGN_W - 1 - i);
            end
        end
    end

    always_comb begin
        norm_exp  = $signed({2'b00, s2_q.exp});
        norm_mant = s2_q.mant[ALIGN_W-1:0];
        if (s2_q.mant[ALIGN_W]) begin
            // Carry out, move right one place
            norm_exp  = norm_exp + 10'sd1;
            norm_mant = s2_q.mant[ALIGN_W:1];
        end else begin
            norm_exp  = norm_exp - $signed({1'b0, lz});
            norm_mant = s2_q.mant[ALIGN_W-1:0] << lz;
        end
        // Only meaningful on the underflow path
        den_shift = 10'sd1 - norm_exp;
        den_mant  = norm_mant >> den_shift;

        s3_d.fields.sign = s2_q.sign;
        if (norm_exp >= EXP_MAX) begin
            // Overflow saturates to signed infinity
            s3_d.fields.exp  = EXP_W'(EXP_MAX);
            s3_d.fields.mant = '0;
        end else if (norm_exp <= 0 || s2_q.mant == '0) begin
            // Exact cancellation also lands here and packs as zero
            s3_d.fields.exp  = '0;
            s3_d.fields.mant = den_mant[ALIGN_W-2 -: MANT_W];
        end else begin
            s3_d.fields.exp  = norm_exp[EXP_W-1:0];
            s3_d.fields.mant = norm_mant[ALIGN_W-2 -: MANT_W];
        end
        if (s2_q.special) begin
            s3_d = s2_q.spec_res;
        end
        // Any zero leaves as +0, bypass results included
        if (s3_d.fields.exp == '0 && s3_d.fields.mant == '0) begin
            s3_d.raw = '0;
        end
    end

    // --------------------
    // Stage registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid  <= in_valid;
            s2_valid  <= s1_valid;
            out_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_q <= s1_d;
            s2_q <= s2_d;
            s3_q <= s3_d;
        end
    end

    assign out_data.res = s3_q;

    // --------------------
    // Checks
    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("lane result changed or vanished before it was taken");

    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid))
        else $error("lane out_valid is unknown");

endmodule

/* source/op_dispatch.sv */
`timescale 1ns/1ps
// Operand dispatcher
// Four-phase receive, round-robin issue

module op_dispatch
    import add_array_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_req,
    input  add_req_t             in_data,
    output logic                 in_ack,
    output logic [NUM_LANES-1:0] lane_valid,
    input  logic [NUM_LANES-1:0] lane_ready,
    output add_req_t             lane_data
);

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_ack_high
    } state_t;

    state_t                state;
    logic [LANE_IDX_W-1:0] ptr;
    logic [LANE_IDX_W-1:0] ptr_next;
    add_req_t              hold;

    // Wrap at the last lane
    assign ptr_next = (ptr == LANE_IDX_W'(NUM_LANES - 1)) ? '0 : ptr + 1'b1;

    assign in_ack    = (state == st_ack_high);
    // All lanes see the pair, only one gets valid
    assign lane_data = hold;

    always_comb begin
        lane_valid      = '0;
        lane_valid[ptr] = (state == st_issue);
    end

    // --------------------
    // Handshake FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            ptr   <= '0;
        end else begin
            case (state)
                st_idle: if (in_req) state <= st_issue;
                st_issue: begin
                    // Lane took the pair
                    if (lane_ready[ptr]) begin
                        state <= st_ack_high;
                        ptr   <= ptr_next;
                    end
                end
                st_ack_high: if (!in_req) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // Pair captured on the first req edge
    always_ff @(posedge clk) begin
        if (state == st_idle && in_req) begin
            hold <= in_data;
        end
    end

    a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_ack) |-> $past(in_req))
        else $error("in_ack rose without in_req");

    // Offer stays put until the lane takes it
    a_offer_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (lane_valid & ~lane_ready) != '0 |=>
            lane_valid == $past(lane_valid) && $stable(lane_data))
        else $error("lane offer changed before the lane took it");

endmodule

/* source/result_collect.sv */
`timescale 1ns/1ps
// Result collector
// In-order lane drain, four-phase send

module result_collect
    import add_array_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_LANES-1:0] lane_valid,
    input  add_rsp_t             lane_data [NUM_LANES],
    output logic [NUM_LANES-1:0] lane_ready,
    output logic                 out_req,
    output add_rsp_t             out_data,
    input  logic                 out_ack
);

    typedef enum logic [1:0] {
        st_idle,
        st_req_high,
        st_wait_ack_low
    } state_t;

    state_t                state;
    logic [LANE_IDX_W-1:0] ptr;
    logic [LANE_IDX_W-1:0] ptr_next;
    logic                  take;
    add_rsp_t              hold;

    assign ptr_next = (ptr == LANE_IDX_W'(NUM_LANES - 1)) ? '0 : ptr + 1'b1;

    // Only the pointer lane is watched, which keeps issue order
    assign take = (state == st_idle) && lane_valid[ptr];

    always_comb begin
        lane_ready      = '0;
        lane_ready[ptr] = take;
    end

    assign out_req  = (state == st_req_high);
    assign out_data = hold;

    // --------------------
    // Handshake FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            ptr   <= '0;
        end else begin
            case (state)
                st_idle: if (take) state <= st_req_high;
                st_req_high: if (out_ack) state <= st_wait_ack_low;
                st_wait_ack_low: begin
                    // Handshake complete, move to next lane
                    if (!out_ack) begin
                        state <= st_idle;
                        ptr   <= ptr_next;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            hold <= lane_data[ptr];
        end
    end

    a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_req |=> !out_req || $stable(out_data))
        else $error("out_data changed while out_req was high");

endmodule

/* source/fp32_add_array.sv */
`timescale 1ns/1ps
// Floating-point adder array top

module fp32_add_array
    import add_array_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_req,
    input  add_req_t in_data,
    output logic     in_ack,
    output logic     out_req,
    output add_rsp_t out_data,
    input  logic     out_ack
);

    // Dispatcher to lanes
    logic [NUM_LANES-1:0] lane_in_valid;
    logic [NUM_LANES-1:0] lane_in_ready;
    add_req_t             lane_in_data;

    // Lanes to collector
    logic [NUM_LANES-1:0] lane_out_valid;
    logic [NUM_LANES-1:0] lane_out_ready;
    add_rsp_t             lane_out_data [NUM_LANES];

    op_dispatch u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_req     (in_req),
        .in_data    (in_data),
        .in_ack     (in_ack),
        .lane_valid (lane_in_valid),
        .lane_ready (lane_in_ready),
        .lane_data  (lane_in_data)
    );

    // --------------------
    // Adder lanes
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        fp32_add_lane u_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (lane_in_valid[i]),
            .in_ready  (lane_in_ready[i]),
            .in_data   (lane_in_data),
            .out_valid (lane_out_valid[i]),
            .out_ready (lane_out_ready[i]),
            .out_data  (lane_out_data[i])
        );
    end

    result_collect u_collect (
        .clk        (clk),
        .rst_n      (rst_n),
        .lane_valid (lane_out_valid),
        .lane_data  (lane_out_data),
        .lane_ready (lane_out_ready),
        .out_req    (out_req),
        .out_data   (out_data),
        .out_ack    (out_ack)
    );

endmodule

/* tb/fp32_ref_model.svh */
// Truncating fp32 add reference

`ifndef FP32_REF_MODEL_SVH
`define FP32_REF_MODEL_SVH

// Expected sum of a and b with truncation and no rounding
function automatic logic [31:0] fp32_add_expect(input logic [31:0] a, input logic [31:0] b);
    logic [31:0] hi;
    logic [31:0] lo;
    logic [48:0] m_hi;
    logic [48:0] m_lo;
    logic [48:0] sum;
    logic [48:0] norm;
    logic [31:0] res;
    int          e_hi;
    int          e_lo;
    int          top;
    int          e;
    // NaN wins over everything
    if ((a[30:23] == 8'hFF && a[22:0] != 0) || (b[30:23] == 8'hFF && b[22:0] != 0)) begin
        res = QNAN;
    end else if (a[30:23] == 8'hFF && b[30:23] == 8'hFF) begin
        res = (a[31] == b[31]) ? a : QNAN;
    end else if (a[30:23] == 8'hFF) begin
        res = a;
    end else if (b[30:23] == 8'hFF) begin
        res = b;
    end else if (a[30:0] == 0) begin
        res = b;
    end else if (b[30:0] == 0) begin
        res = a;
    end else begin
        // Larger magnitude first, a on a tie
        hi = (a[30:0] >= b[30:0]) ? a : b;
        lo = (a[30:0] >= b[30:0]) ? b : a;
        // Denormals act as exponent 1 with no hidden one
        e_hi = (hi[30:23] == 0) ? 1 : int'(hi[30:23]);
        e_lo = (lo[30:23] == 0) ? 1 : int'(lo[30:23]);
        m_hi = {1'b0, hi[30:23] != 0, hi[22:0], 24'h0};
        m_lo = {1'b0, lo[30:23] != 0, lo[22:0], 24'h0};
        m_lo = (e_hi - e_lo >= 48) ? '0 : m_lo >> (e_hi - e_lo);
        sum  = (hi[31] == lo[31]) ? m_hi + m_lo : m_hi - m_lo;
        if (sum == 0) begin
            res = '0;
        end else begin
            top = 48;
            while (!sum[top]) top--;
            // Biased exponent of the leading one
            e    = e_hi + top - 47;
            norm = sum << (48 - top);
            if (e >= 255) begin
                res = {hi[31], 8'hFF, 23'h0};
            end else if (e >= 1) begin
                res = {hi[31], 8'(e), norm[47:25]};
            end else begin
                res = {hi[31], 8'h00, 23'(sum >> (25 - e_hi))};
            end
        end
    end
    // Zero leaves positive
    if (res[30:0] == 0) res = '0;
    return res;
endfunction

`endif

/* tb/tb_fp32_add_array.sv */
`timescale 1ns/1ps
// Adder array testbench

module tb_fp32_add_array
    import fp32_pkg::*;
    import add_array_pkg::*;
();

    `include "fp32_ref_model.svh"

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int N_DIRECTED   = 20;
    localparam int N_RANDOM     = 200;
    localparam int N_BURST      = 120;
    localparam int HOLD_CYCLES  = 80;
    localparam int NUM_OPS      = N_DIRECTED + N_RANDOM + N_BURST;

    // Operand pairs {a, b}: NaN, inf, zero, overflow, denormal, cancel
    localparam logic [63:0] DIRECTED [N_DIRECTED] = '{
        64'h7FC00000_3F800000, 64'h3F800000_7F800001, 64'h7F800000_7F800000,
        64'hFF800000_FF800000, 64'h7F800000_FF800000, 64'hFF800000_7F800000,
        64'h7F800000_40400000, 64'hC0A00000_FF800000, 64'h00000000_40200000,
        64'hBFC00000_00000000, 64'h80000000_80000000, 64'h3F800000_BF800000,
        64'h7F7FFFFF_7F7FFFFF, 64'hFF7FFFFF_FF000000, 64'h00400000_00400000,
        64'h00800001_80800000, 64'h00000003_80000001, 64'h3F800001_BF800000,
        64'h00C00000_80800000, 64'h7FFFFFFF_FF800000
    };

    logic     clk;
    logic     rst_n;
    logic     in_req;
    add_req_t in_data;
    logic     in_ack;
    logic     out_req;
    add_rsp_t out_data;
    logic     out_ack;

    integer               seed = 73898;
    logic [31:0]          exp_q [$];
    logic [31:0]          exp_front;
    int                   exp_count;
    int                   sent_count;
    int                   rcv_count;
    logic                 started;
    logic                 hold_sink;
    logic                 saw_stall;
    logic [NUM_LANES-1:0] lane_held;

    fp32_add_array uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_req   (in_req),
        .in_data  (in_data),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_data (out_data),
        .out_ack  (out_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------
    // Helpers
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "run stopped on error");
    endtask

    // Inputs change and outputs are read 1 ns after the edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic refresh_front();
        exp_count = exp_q.size();
        exp_front = (exp_count > 0) ? exp_q[0] : '0;
    endtask

    // Random word forced into the normal range
    function automatic logic [31:0] make_normal(input logic [31:0] r);
        return {r[31], (r[30:23] == 0) ? 8'd1 : ((r[30:23] == 8'hFF) ? 8'hFE : r[30:23]),
                r[22:0]};
    endfunction

    // Four-phase source, one pair
    task automatic send_pair(input logic [31:0] a, input logic [31:0] b);
        while (in_ack) tick();
        started         = 1'b1;
        in_data.a.raw   = a;
        in_data.b.raw   = b;
        in_req          = 1'b1;
        exp_q.push_back(fp32_add_expect(a, b));
        refresh_front();
        sent_count++;
        do tick(); while (!in_ack);
        // Req may linger a few cycles past the ack
        repeat ($unsigned($random(seed)) % 3) tick();
        in_req = 1'b0;
    endtask

    // --------------------
    // Sink with random ack delay
    initial begin : sink
        int delay;
        wait (rst_n === 1'b1);
        forever begin
            tick();
            if (out_req && !hold_sink) begin
                delay = $unsigned($random(seed)) % 7;
                repeat (delay) tick();
                out_ack = 1'b1;
                do tick(); while (out_req);
                out_ack = 1'b0;
                void'(exp_q.pop_front());
                refresh_front();
                rcv_count++;
            end
        end
    end

    // Back-pressure seen inside the array
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            saw_stall <= 1'b0;
            lane_held <= '0;
        end else begin
            if (|(uut.lane_in_valid & ~uut.lane_in_ready)) saw_stall <= 1'b1;
            lane_held <= lane_held | (uut.lane_out_valid & ~uut.lane_out_ready);
        end
    end

    // --------------------
    // Checks
    a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !in_ack && !out_req)
        else abort_run("in_ack or out_req went high before the first operand pair");

    a_ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_ack) |-> $past(in_req))
        else abort_run("in_ack rose while in_req was low");

    a_ack_drops_late: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(in_ack) |-> $past(!in_req))
        else abort_run("in_ack fell before in_req was dropped");

    a_req_drops_late: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(out_req) |-> $past(out_ack))
        else abort_run("out_req fell before out_ack was raised");

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_req |=> !out_req || $stable(out_data))
        else abort_run("out_data changed while out_req was high");

    a_result_expected: assert property (@(posedge clk) disable iff (!rst_n)
        out_req |-> exp_count > 0)
        else abort_run("a result arrived with no operation outstanding");

    a_result_value: assert property (@(posedge clk) disable iff (!rst_n)
        out_req && exp_count > 0 |-> out_data.res.raw == exp_front)
        else abort_run($sformatf("Mismatch at %0t: result %h, expected %h",
            $time, out_data.res.raw, exp_front));

    // Watchdog sized from the operation count
    initial begin
        #((RESET_CYCLES + NUM_OPS * 40) * CLK_PERIOD);
        abort_run("Timeout: the run did not finish in the allowed time");
    end

    // --------------------
    // Stimulus
    initial begin : main
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] a;
        logic [31:0] b;
        string       fail_reason;
        rst_n      = 1'b0;
        in_req     = 1'b0;
        in_data    = '0;
        out_ack    = 1'b0;
        started    = 1'b0;
        hold_sink  = 1'b0;
        sent_count = 0;
        rcv_count  = 0;
        refresh_front();
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (4) tick();

        for (int i = 0; i < N_DIRECTED; i++) begin
            send_pair(DIRECTED[i][63:32], DIRECTED[i][31:0]);
        end

        // Mixed signs, same exponent, negation and tiny values
        for (int i = 0; i < N_RANDOM; i++) begin
            ra = $random(seed);
            rb = $random(seed);
            a  = make_normal(ra);
            case (i % 4)
                0: b = make_normal(rb);
                1: b = {rb[31], a[30:23], rb[22:0]};
                2: b = a ^ 32'h8000_0000;
                default: begin
                    a = {ra[31], 6'b0, ra[24:23], ra[22:0]};
                    b = {~ra[31], 6'b0, rb[24:23], rb[22:0]};
                end
            endcase
            send_pair(a, b);
        end

        // Sink pauses so every lane fills and input stalls
        fork
            begin
                hold_sink = 1'b1;
                repeat (HOLD_CYCLES) tick();
                hold_sink = 1'b0;
            end
        join_none
        for (int i = 0; i < N_BURST; i++) begin
            ra = $random(seed);
            rb = $random(seed);
            send_pair(make_normal(ra), make_normal(rb));
        end

        while (exp_count != 0) tick();
        repeat (20) tick();

        fail_reason = "";
        if (rcv_count != sent_count) begin
            fail_reason = $sformatf("received %0d results for %0d operand pairs",
                rcv_count, sent_count);
        end else if (!saw_stall) begin
            fail_reason = "the input side never stalled during the burst";
        end else if (lane_held != '1) begin
            fail_reason = $sformatf("not every lane filled up, held mask %b", lane_held);
        end
        if (fail_reason != "") begin
            abort_run(fail_reason);
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

/* flist.f */
+incdir+tb
source/fp32_pkg.sv
source/add_array_pkg.sv
source/fp32_add_lane.sv
source/op_dispatch.sv
source/result_collect.sv
source/fp32_add_array.sv
tb/tb_fp32_add_array.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_fp32_add_array
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
